// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_pipeline
FILELIST  = project.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: project.f
rtl/core_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/register_file.sv
rtl/decode_execute_reg.sv
rtl/execute_stage.sv
rtl/pipeline_top.sv
verif/pipeline_checker.sv
verif/tb_pipeline.sv

// File: rtl/core_pkg.sv
// Shared types for the pipelined ARM subset core
// Word, register, flag and condition types, ALU codes and pipeline records
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;
    // N Z C V, N in the top bit
    typedef logic [3:0]  flags_t;
    typedef logic [3:0]  cond_t;
    typedef logic [2:0]  alu_ctrl_t;
    // Bit 1 updates N and Z, bit 0 updates C and V
    typedef logic [1:0]  flag_write_t;

    localparam alu_ctrl_t ALU_ADD   = 3'd0;
    localparam alu_ctrl_t ALU_SUB   = 3'd1;
    localparam alu_ctrl_t ALU_AND   = 3'd2;
    localparam alu_ctrl_t ALU_ORR   = 3'd3;
    localparam alu_ctrl_t ALU_PASSB = 3'd4;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_BUS,
        FETCH_DROP
    } fetch_state_t;

    // Fetch slot handed to decode
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_t;

    typedef struct packed {
        logic        reg_write;
        alu_ctrl_t   alu_ctrl;
        logic        branch;
        logic        alu_src;
        flag_write_t flag_write;
        cond_t       cond;
        logic        is_op;
    } de_ctrl_t;

    typedef struct packed {
        word_t     rd1;
        word_t     rd2;
        reg_addr_t wa3;
        word_t     ext_imm;
        word_t     pc;
    } de_data_t;

    typedef struct packed {
        logic     valid;
        de_ctrl_t ctrl;
        de_data_t data;
    } de_t;

    // One record per instruction leaving execute, flags as left behind by it
    typedef struct packed {
        word_t     pc;
        logic      executed;
        logic      reg_write;
        reg_addr_t rd;
        word_t     result;
        flags_t    flags;
    } retire_t;

endpackage

`default_nettype wire

// File: rtl/decode_execute_reg.sv
// Decode/execute pipeline register with valid bit and flush
`timescale 1ns/1ps
`default_nettype none

module decode_execute_reg import core_pkg::*; (
    input  logic i_clk,
    input  logic i_rst,
    // Branch taken in execute
    input  logic i_flush,
    // Record from decode
    input  de_t  i_de,
    // Record into execute
    output de_t  o_de
);

    de_t de_q;

    // Only valid needs clearing, payload follows decode
    always_ff @(posedge i_clk) begin
        if (i_rst || i_flush) begin
            de_q.valid <= 1'b0;
        end else begin
            de_q <= i_de;
        end
    end

    assign o_de = de_q;

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
// Instruction decode, operand read, RAW hazard stall
// Builds the decode/execute record
`timescale 1ns/1ps
`default_nettype none

module decode_stage import core_pkg::*; (
    input  fetch_t    i_fetch,
    input  logic      i_flush,
    output reg_addr_t o_ra1,
    output reg_addr_t o_ra2,
    input  word_t     i_rd1,
    input  word_t     i_rd2,
    input  de_t       i_ex_de,
    output logic      o_stall,
    output de_t       o_de
);

    localparam logic [3:0] CMD_AND = 4'b0000;
    localparam logic [3:0] CMD_SUB = 4'b0010;
    localparam logic [3:0] CMD_ADD = 4'b0100;
    localparam logic [3:0] CMD_CMP = 4'b1010;
    localparam logic [3:0] CMD_ORR = 4'b1100;
    localparam logic [3:0] CMD_MOV = 4'b1101;

    word_t      instr;
    cond_t      cond;
    logic [3:0] cmd;
    logic       imm_bit;
    logic       is_dp;
    logic       is_b;
    logic       uses_rn;
    logic       uses_rm;
    logic       hazard;
    de_ctrl_t   ctrl;

    assign instr   = i_fetch.instr;
    assign cond    = instr[31:28];
    assign cmd     = instr[24:21];
    assign imm_bit = instr[25];

    // Data processing without rotate or shift, supported commands only
    assign is_dp = (instr[27:26] == 2'b00) && (cond != 4'hF) &&
                   (imm_bit ? (instr[11:8] == 4'h0) : (instr[11:4] == 8'h00)) &&
                   (cmd inside {CMD_AND, CMD_SUB, CMD_ADD, CMD_CMP, CMD_ORR, CMD_MOV});
    // B without link
    assign is_b  = (instr[27:24] == 4'b1010) && (cond != 4'hF);

    assign uses_rn = is_dp && (cmd != CMD_MOV);
    assign uses_rm = is_dp && !imm_bit;

    assign o_ra1 = instr[19:16];
    assign o_ra2 = instr[3:0];

    always_comb begin
        ctrl         = '0;
        ctrl.cond    = cond;
        ctrl.is_op   = is_dp || is_b;
        ctrl.alu_src = imm_bit;
        ctrl.branch  = is_b;
        if (is_dp) begin
            // R15 as destination is dropped here
            ctrl.reg_write = (cmd != CMD_CMP) && (instr[15:12] != 4'hF);
            case (cmd)
                CMD_AND:          ctrl.alu_ctrl = ALU_AND;
                CMD_SUB, CMD_CMP: ctrl.alu_ctrl = ALU_SUB;
                CMD_ADD:          ctrl.alu_ctrl = ALU_ADD;
                CMD_ORR:          ctrl.alu_ctrl = ALU_ORR;
                default:          ctrl.alu_ctrl = ALU_PASSB;
            endcase
            if (cmd == CMD_CMP) begin
                ctrl.flag_write = 2'b11;
            end else if (instr[20]) begin
                // Logical ops and MOV touch only N and Z
                ctrl.flag_write = (cmd == CMD_ADD || cmd == CMD_SUB) ? 2'b11 : 2'b10;
            end
        end
    end

    // No forwarding, wait for the producer to reach writeback
    assign hazard = i_ex_de.valid && i_ex_de.ctrl.reg_write &&
                    ((uses_rn && (i_ex_de.data.wa3 == o_ra1)) ||
                     (uses_rm && (i_ex_de.data.wa3 == o_ra2)));
    assign o_stall = i_fetch.valid && hazard;

    always_comb begin
        o_de.valid     = i_fetch.valid && !hazard && !i_flush;
        o_de.ctrl      = ctrl;
        o_de.data.rd1  = i_rd1;
        o_de.data.rd2  = i_rd2;
        o_de.data.wa3  = instr[15:12];
        o_de.data.pc   = i_fetch.pc;
        // Branch word offset or zero-extended imm8
        o_de.data.ext_imm = is_b ? {{6{instr[23]}}, instr[23:0], 2'b00}
                                 : {24'h000000, instr[7:0]};
    end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
// Execute: condition check, ALU, flags register, branch resolution
// Execute/writeback register feeding the write port and the retire port
`timescale 1ns/1ps
`default_nettype none

module execute_stage import core_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  de_t       i_de,
    output logic      o_redirect,
    output word_t     o_target,
    output logic      o_we,
    output reg_addr_t o_wa,
    output word_t     o_wd,
    output logic      o_retire_valid,
    output retire_t   o_retire
);

    flags_t    flags_q;
    flags_t    flags_d;
    logic      executed;
    word_t     src_a;
    word_t     src_b;
    word_t     b_op;
    logic      sub;
    logic [32:0] sum;
    word_t     alu_result;
    logic      carry;
    logic      overflow;
    logic      retire_valid_q;
    retire_t   retire_q;

    function automatic logic cond_pass(input cond_t cond, input flags_t f);
        logic n, z, c, v;
        {n, z, c, v} = f;
        case (cond)
            4'h0: return z;
            4'h1: return !z;
            4'h2: return c;
            4'h3: return !c;
            4'h4: return n;
            4'h5: return !n;
            4'h6: return v;
            4'h7: return !v;
            4'h8: return c && !z;
            4'h9: return !c || z;
            4'hA: return n == v;
            4'hB: return n != v;
            4'hC: return !z && (n == v);
            4'hD: return z || (n != v);
            4'hE: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    assign executed = i_de.valid && i_de.ctrl.is_op && cond_pass(i_de.ctrl.cond, flags_q);

    assign src_a = i_de.data.rd1;
    assign src_b = i_de.ctrl.alu_src ? i_de.data.ext_imm : i_de.data.rd2;

    // Subtract as a + ~b + 1, carry out is then "no borrow"
    assign sub      = (i_de.ctrl.alu_ctrl == ALU_SUB);
    assign b_op     = sub ? ~src_b : src_b;
    assign sum      = {1'b0, src_a} + {1'b0, b_op} + {32'd0, sub};
    assign carry    = sum[32];
    assign overflow = (src_a[31] == b_op[31]) && (sum[31] != src_a[31]);

    always_comb begin
        case (i_de.ctrl.alu_ctrl)
            ALU_ADD, ALU_SUB: alu_result = sum[31:0];
            ALU_AND:          alu_result = src_a & src_b;
            ALU_ORR:          alu_result = src_a | src_b;
            default:          alu_result = src_b;
        endcase
    end

    always_comb begin
        flags_d = flags_q;
        if (executed && i_de.ctrl.flag_write[1]) begin
            flags_d[3:2] = {alu_result[31], alu_result == 32'd0};
        end
        if (executed && i_de.ctrl.flag_write[0]) begin
            flags_d[1:0] = {carry, overflow};
        end
    end

    assign o_redirect = executed && i_de.ctrl.branch;
    assign o_target   = i_de.data.pc + 32'd8 + i_de.data.ext_imm;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            flags_q        <= '0;
            retire_valid_q <= 1'b0;
        end else begin
            flags_q        <= flags_d;
            retire_valid_q <= i_de.valid;
        end
    end

    // Branches report their target as the result
    always_ff @(posedge i_clk) begin
        retire_q.pc        <= i_de.data.pc;
        retire_q.executed  <= executed;
        retire_q.reg_write <= executed && i_de.ctrl.reg_write;
        retire_q.rd        <= i_de.data.wa3;
        retire_q.result    <= i_de.ctrl.branch ? o_target : alu_result;
        retire_q.flags     <= flags_d;
    end

    assign o_we           = retire_valid_q && retire_q.reg_write;
    assign o_wa           = retire_q.rd;
    assign o_wd           = retire_q.result;
    assign o_retire_valid = retire_valid_q;
    assign o_retire       = retire_q;

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
// Instruction fetch: PC, Wishbone classic read master and one-entry slot
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import core_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_redirect,
    input  word_t  i_target,
    input  logic   i_stall,
    output fetch_t o_fetch,
    output logic   o_wb_cyc,
    output logic   o_wb_stb,
    output logic   o_wb_we,
    output word_t  o_wb_adr,
    input  word_t  i_wb_dat,
    input  logic   i_wb_ack
);

    fetch_state_t state_q;
    word_t        pc_q;
    word_t        adr_q;
    fetch_t       slot_q;
    logic         start;

    // Slot is free now or decode takes it this cycle
    assign start = (state_q == FETCH_IDLE) && !i_redirect &&
                   (!slot_q.valid || !i_stall);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q      <= FETCH_IDLE;
            pc_q         <= RESET_PC;
            slot_q.valid <= 1'b0;
        end else begin
            if (slot_q.valid && !i_stall) begin
                slot_q.valid <= 1'b0;
            end
            case (state_q)
                FETCH_IDLE: begin
                    if (start) begin
                        state_q <= FETCH_BUS;
                    end
                end
                FETCH_BUS: begin
                    if (i_wb_ack) begin
                        state_q <= FETCH_IDLE;
                        // Word arriving with a redirect is wrong-path
                        if (!i_redirect) begin
                            slot_q <= '{valid: 1'b1, pc: adr_q, instr: i_wb_dat};
                            pc_q   <= pc_q + 32'd4;
                        end
                    end else if (i_redirect) begin
                        state_q <= FETCH_DROP;
                    end
                end
                FETCH_DROP: begin
                    if (i_wb_ack) begin
                        state_q <= FETCH_IDLE;
                    end
                end
                default: state_q <= FETCH_IDLE;
            endcase
            if (i_redirect) begin
                pc_q         <= i_target;
                slot_q.valid <= 1'b0;
            end
        end
    end

    // Address latched at request start, held until ack
    always_ff @(posedge i_clk) begin
        if (start) begin
            adr_q <= pc_q;
        end
    end

    assign o_wb_cyc = (state_q != FETCH_IDLE);
    assign o_wb_stb = (state_q != FETCH_IDLE);
    assign o_wb_we  = 1'b0;
    assign o_wb_adr = adr_q;
    assign o_fetch  = slot_q;

endmodule

`default_nettype wire

// File: rtl/pipeline_top.sv
// Core top level: fetch, decode, register file, D/E register, execute
// Wishbone fetch port and retire trace port
`timescale 1ns/1ps
`default_nettype none

module pipeline_top import core_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic    i_clk,
    input  logic    i_rst,
    output logic    o_wb_cyc,
    output logic    o_wb_stb,
    output logic    o_wb_we,
    output word_t   o_wb_adr,
    input  word_t   i_wb_dat,
    input  logic    i_wb_ack,
    output logic    o_retire_valid,
    output retire_t o_retire
);

    fetch_t    fetch;
    logic      stall;
    logic      redirect;
    word_t     target;
    reg_addr_t ra1;
    reg_addr_t ra2;
    word_t     rd1;
    word_t     rd2;
    de_t       dec_de;
    de_t       ex_de;
    logic      we;
    reg_addr_t wa;
    word_t     wd;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_redirect (redirect),
        .i_target   (target),
        .i_stall    (stall),
        .o_fetch    (fetch),
        .o_wb_cyc   (o_wb_cyc),
        .o_wb_stb   (o_wb_stb),
        .o_wb_we    (o_wb_we),
        .o_wb_adr   (o_wb_adr),
        .i_wb_dat   (i_wb_dat),
        .i_wb_ack   (i_wb_ack)
    );

    decode_stage u_decode (
        .i_fetch (fetch),
        .i_flush (redirect),
        .o_ra1   (ra1),
        .o_ra2   (ra2),
        .i_rd1   (rd1),
        .i_rd2   (rd2),
        .i_ex_de (ex_de),
        .o_stall (stall),
        .o_de    (dec_de)
    );

    // PC of the decoding instruction gives the R15 read value
    register_file u_regfile (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_ra1 (ra1),
        .i_ra2 (ra2),
        .i_pc  (fetch.pc),
        .o_rd1 (rd1),
        .o_rd2 (rd2),
        .i_we  (we),
        .i_wa  (wa),
        .i_wd  (wd)
    );

    decode_execute_reg u_de_reg (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_flush (redirect),
        .i_de    (dec_de),
        .o_de    (ex_de)
    );

    execute_stage u_execute (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_de           (ex_de),
        .o_redirect     (redirect),
        .o_target       (target),
        .o_we           (we),
        .o_wa           (wa),
        .o_wd           (wd),
        .o_retire_valid (o_retire_valid),
        .o_retire       (o_retire)
    );

endmodule

`default_nettype wire

// File: rtl/register_file.sv
// 16x32 register file with two read ports, one write port and write-through
`timescale 1ns/1ps
`default_nettype none

module register_file import core_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  reg_addr_t i_ra1,
    input  reg_addr_t i_ra2,
    input  word_t     i_pc,
    output word_t     o_rd1,
    output word_t     o_rd2,
    input  logic      i_we,
    input  reg_addr_t i_wa,
    input  word_t     i_wd
);

    word_t regs_q [16];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 16; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_we && (i_wa != 4'hF)) begin
            regs_q[i_wa] <= i_wd;
        end
    end

    // R15 reads as PC + 8 and a write in flight reaches decode at once
    function automatic word_t read_port(input reg_addr_t ra);
        if (ra == 4'hF) begin
            return i_pc + 32'd8;
        end else if (i_we && (i_wa == ra)) begin
            return i_wd;
        end
        return regs_q[ra];
    endfunction

    always_comb begin
        o_rd1 = read_port(i_ra1);
        o_rd2 = read_port(i_ra2);
    end

endmodule

`default_nettype wire

// File: verif/pipeline_checker.sv
// Bound protocol checker for the core
// Wishbone fetch rules and retire quiet during reset
`timescale 1ns/1ps
`default_nettype none

module pipeline_checker import core_pkg::*; (
    input logic  i_clk,
    input logic  i_rst,
    input logic  i_wb_cyc,
    input logic  i_wb_stb,
    input logic  i_wb_we,
    input word_t i_wb_adr,
    input logic  i_wb_ack,
    input logic  i_retire_valid
);

    // Strobe only inside a bus cycle
    stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_stb |-> i_wb_cyc)
        else $error("Wishbone stb high while cyc is low");

    // Request held with a steady address until the slave acks
    req_held: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_wb_stb && !i_wb_ack) |=> (i_wb_cyc && i_wb_stb && $stable(i_wb_adr)))
        else $error("Wishbone request dropped or address changed before ack");

    // Fetch port is read only
    no_write: assert property (@(posedge i_clk) !i_wb_we)
        else $error("Wishbone write enable raised by the fetch port");

    quiet_in_reset: assert property (@(posedge i_clk) i_rst |=> !i_retire_valid)
        else $error("Retire valid high while reset is applied");

endmodule

`default_nettype wire

// File: verif/tb_pipeline.sv
// Core testbench with a random program and a Wishbone memory with random ack delay
// ISA reference model and retire comparator
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline import core_pkg::*; ();

    localparam int PROG_WORDS     = 64;
    localparam int NUM_RETIRES    = 300;
    localparam int RESET_CYCLES   = 16;
    localparam int RETIRE_TIMEOUT = 200;
    localparam int REQ_TIMEOUT    = 100;

    // ARM data-processing opcodes
    localparam logic [3:0] OP_AND = 4'h0;
    localparam logic [3:0] OP_SUB = 4'h2;
    localparam logic [3:0] OP_ADD = 4'h4;
    localparam logic [3:0] OP_CMP = 4'ha;
    localparam logic [3:0] OP_ORR = 4'hc;
    localparam logic [3:0] OP_MOV = 4'hd;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    word_t       wb_adr;
    word_t       wb_dat;
    logic        wb_ack;
    logic        retire_valid;
    retire_t     retire;
    word_t       prog [PROG_WORDS];
    logic [31:0] rng;
    word_t       model_regs [16];
    flags_t      model_flags;
    word_t       model_pc;
    logic        model_branch;

    pipeline_top #(
        .RESET_PC (32'h0000_0000)
    ) dut0 (
        .i_clk          (clk),
        .i_rst          (rst),
        .o_wb_cyc       (wb_cyc),
        .o_wb_stb       (wb_stb),
        .o_wb_we        (wb_we),
        .o_wb_adr       (wb_adr),
        .i_wb_dat       (wb_dat),
        .i_wb_ack       (wb_ack),
        .o_retire_valid (retire_valid),
        .o_retire       (retire)
    );

    bind pipeline_top pipeline_checker checker0 (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_wb_cyc       (o_wb_cyc),
        .i_wb_stb       (o_wb_stb),
        .i_wb_we        (o_wb_we),
        .i_wb_adr       (o_wb_adr),
        .i_wb_ack       (i_wb_ack),
        .i_retire_valid (o_retire_valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Outside the program the word is built from the full address
    function automatic word_t mem_read(input word_t adr);
        if (adr[31:8] != 24'd0) begin
            return ~adr;
        end
        return prog[adr[7:2]];
    endfunction

    // Each odd condition code inverts the even one below it
    function automatic logic cond_holds(input cond_t cond, input flags_t f);
        logic base;
        case (cond[3:1])
            3'd0:    base = f[2];
            3'd1:    base = f[1];
            3'd2:    base = f[3];
            3'd3:    base = f[0];
            3'd4:    base = f[1] && !f[2];
            3'd5:    base = (f[3] == f[0]);
            3'd6:    base = !f[2] && (f[3] == f[0]);
            default: base = 1'b1;
        endcase
        return base ^ cond[0];
    endfunction

    function automatic word_t read_reg(input reg_addr_t ra, input word_t pc);
        return (ra == 4'hF) ? pc + 32'd8 : model_regs[ra];
    endfunction

    // Steps one instruction in program order
    function automatic retire_t model_step();
        retire_t            r;
        word_t              instr;
        word_t              a;
        word_t              b;
        word_t              res;
        logic [32:0]        wide;
        logic [3:0]         cmd;
        logic               pass;
        logic               dp_ok;
        logic               carry;
        logic               overflow;
        logic signed [31:0] offset;
        instr = mem_read(model_pc);
        cmd   = instr[24:21];
        pass  = cond_holds(instr[31:28], model_flags);
        dp_ok = (instr[27:26] == 2'b00) && (instr[31:28] != 4'hF) &&
                (instr[25] ? (instr[11:8] == 4'h0) : (instr[11:4] == 8'h00)) &&
                (cmd inside {OP_AND, OP_SUB, OP_ADD, OP_CMP, OP_ORR, OP_MOV});
        r            = '0;
        r.pc         = model_pc;
        r.rd         = instr[15:12];
        model_pc     = model_pc + 32'd4;
        model_branch = 1'b0;
        if ((instr[27:24] == 4'b1010) && (instr[31:28] != 4'hF)) begin
            // Branches report their target as the result
            model_branch = 1'b1;
            offset       = $signed(instr[23:0]);
            r.executed   = pass;
            r.result     = r.pc + 32'd8 + (offset << 2);
            if (pass) begin
                model_pc = r.result;
            end
        end else if (dp_ok && pass) begin
            r.executed = 1'b1;
            a        = read_reg(instr[19:16], r.pc);
            b        = instr[25] ? {24'd0, instr[7:0]} : read_reg(instr[3:0], r.pc);
            wide     = {1'b0, a} + {1'b0, b};
            carry    = wide[32];
            overflow = (a[31] == b[31]) && (wide[31] != a[31]);
            case (cmd)
                OP_AND: res = a & b;
                OP_ORR: res = a | b;
                OP_MOV: res = b;
                OP_ADD: res = wide[31:0];
                default: begin
                    // SUB and CMP set carry when there is no borrow
                    res      = a - b;
                    carry    = (a >= b);
                    overflow = (a[31] != b[31]) && (res[31] != a[31]);
                end
            endcase
            if (cmd == OP_CMP || instr[20]) begin
                model_flags[3:2] = {res[31], res == 32'd0};
            end
            if (cmd == OP_CMP || (instr[20] && (cmd == OP_ADD || cmd == OP_SUB))) begin
                model_flags[1:0] = {carry, overflow};
            end
            if (cmd != OP_CMP && instr[15:12] != 4'hF) begin
                model_regs[instr[15:12]] = res;
                r.reg_write = 1'b1;
                r.result    = res;
            end
        end
        r.flags = model_flags;
        return r;
    endfunction

    task automatic build_program();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [3:0]  cond;
        logic [3:0]  cmd;
        logic [3:0]  rn;
        logic [3:0]  rd;
        logic [3:0]  prev_rd;
        logic        s_bit;
        logic [11:0] op2;
        prev_rd = 4'd0;
        for (int i = 0; i < PROG_WORDS - 1; i++) begin
            rng  = xorshift32(rng);
            r1   = rng;
            rng  = xorshift32(rng);
            r2   = rng;
            cond = r1[4] ? 4'hE : (r1[8:5] % 4'd14);
            rn   = r2[22] ? prev_rd : {1'b0, r2[7:5]};
            rd   = {1'b0, r2[10:8]};
            op2  = r2[3] ? {4'h0, r2[21:14]} : {8'h00, 1'b0, r2[13:11]};
            if (r2[23] && !r2[3]) begin
                op2 = {8'h00, prev_rd};
            end
            if ((r1[2:0] == 3'd0) && (i < PROG_WORDS - 4)) begin
                // Forward branch skipping 1 to 3 words
                prog[i] = {cond, 4'b1010, 22'd0, r1[10:9] % 2'd3};
            end else if (r1[3:0] == 4'b1001) begin
                // EOR is outside the subset
                prog[i] = {cond, 3'b000, 4'b0001, r2[4], rn, rd, 8'h00, 1'b0, r2[13:11]};
            end else begin
                case (r2[26:24])
                    3'd0:       cmd = OP_AND;
                    3'd1, 3'd7: cmd = OP_SUB;
                    3'd2, 3'd6: cmd = OP_ADD;
                    3'd3:       cmd = OP_CMP;
                    3'd4:       cmd = OP_ORR;
                    default:    cmd = OP_MOV;
                endcase
                s_bit = r2[4] || (cmd == OP_CMP);
                if (cmd == OP_CMP) begin
                    rd = 4'd0;
                end
                if (cmd == OP_MOV) begin
                    rn = 4'd0;
                end
                prog[i] = {cond, 2'b00, r2[3], cmd, s_bit, rn, rd, op2};
                if (cmd != OP_CMP) begin
                    prev_rd = rd;
                end
            end
        end
        // Branch to itself ends the program
        prog[PROG_WORDS - 1] = 32'hEAFF_FFFE;
    endtask

    task automatic stop_failed();
        $display("SIMULATION FAILED");
        $fatal(1, "testbench stopped on the first error");
    endtask

    task automatic abort_run(input string why);
        $display("Error: %s", why);
        stop_failed();
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            stop_failed();
        end
    endtask

    // Result holds the written value or the branch target
    task automatic check_retire(input int idx, input retire_t exp, input retire_t act,
                                input logic is_branch);
        string tag;
        tag = $sformatf("retire %0d at pc %h", idx, exp.pc);
        check_value({tag, " pc"}, exp.pc, act.pc);
        check_value({tag, " executed"}, {31'd0, exp.executed}, {31'd0, act.executed});
        check_value({tag, " reg_write"}, {31'd0, exp.reg_write}, {31'd0, act.reg_write});
        check_value({tag, " flags"}, {28'd0, exp.flags}, {28'd0, act.flags});
        if (exp.reg_write) begin
            check_value({tag, " rd"}, {28'd0, exp.rd}, {28'd0, act.rd});
        end
        if (exp.reg_write || is_branch) begin
            check_value({tag, " result"}, exp.result, act.result);
        end
    endtask

    task automatic wait_retire();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!retire_valid) begin
            @(negedge clk);
            cycles++;
            if (cycles > RETIRE_TIMEOUT) begin
                abort_run("no instruction retired within the timeout");
            end
        end
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Fetch bus slave with 0 to 3 wait cycles per request
    initial begin : wishbone_memory
        int waited;
        int delay;
        waited = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > 4 * RESET_CYCLES) begin
                abort_run("reset was never released");
            end
        end
        forever begin
            waited = 0;
            while (!(wb_cyc && wb_stb)) begin
                @(negedge clk);
                waited++;
                if (waited > REQ_TIMEOUT) begin
                    abort_run("fetch issued no Wishbone request within the timeout");
                end
            end
            rng   = xorshift32(rng);
            delay = int'(rng[1:0]);
            repeat (delay) @(negedge clk);
            wb_ack = 1'b1;
            wb_dat = mem_read(wb_adr);
            @(negedge clk);
            wb_ack = 1'b0;
            wb_dat = '0;
        end
    end

    initial begin : comparator
        retire_t expected;
        rst         = 1'b1;
        wb_ack      = 1'b0;
        wb_dat      = '0;
        rng         = 32'hb0dd;
        model_pc    = 32'h0000_0000;
        model_flags = '0;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = '0;
        end
        build_program();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        for (int n = 0; n < NUM_RETIRES; n++) begin
            wait_retire();
            expected = model_step();
            check_retire(n, expected, retire, model_branch);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
